// ==== bench/hci_wide_port_sva.sv ====
/*
  protocol assertions on grant and r_valid
  bound into the top level of the wide port
*/

`timescale 1ns/1ps
`default_nettype none

module hci_wide_port_sva (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         clear_i,
  input logic                         gnt_i,
  input hci_pkg::hci_wide_req_t       req_i,
  input logic [hci_pkg::NB_BANKS-1:0] bank_busy_i,
  input hci_pkg::hci_wide_resp_t      resp_i
);

  // busy bits of the banks the lanes land on, lane 0 in bit 0
  logic [2*hci_pkg::NB_BANKS-1:0] busy_win_s;

  assign busy_win_s = {bank_busy_i, bank_busy_i} >> req_i.add.raw[hci_pkg::OFS_W+1:2];

  // a response always belongs to the grant one cycle earlier
  a_valid_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_i.r_valid |-> $past(gnt_i))
    else $error("r_valid without a grant in the previous cycle");

  // flush in the grant cycle is the only way to lose the response
  a_gnt_gives_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_i && !clear_i |=> resp_i.r_valid)
    else $error("grant not followed by r_valid");

  a_no_gnt_when_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_i |-> req_i.req && (busy_win_s[hci_pkg::NB_LANES-1:0] == '0))
    else $error("grant while a touched bank is busy");

endmodule

bind hci_wide_port_top hci_wide_port_sva u_sva (
  .clk_i       ( clk_i          ),
  .rst_ni      ( rst_ni         ),
  .clear_i     ( clear_i        ),
  .gnt_i       ( gnt_o          ),
  .req_i       ( req_i          ),
  .bank_busy_i ( bank_busy_i    ),
  .resp_i      ( resp_o         )
);

`default_nettype wire

// ==== bench/hci_wide_port_tb.sv ====
/*
  testbench for the wide port subsystem
  preload, directed table and LCG random traffic
  reference word model, grant and response compare tasks
*/

`timescale 1ns/1ps
`default_nettype none

module hci_wide_port_tb;

  localparam int unsigned WIDX_W       = hci_pkg::BANK_AW + hci_pkg::OFS_W;
  localparam int unsigned MODEL_WORDS  = 2**WIDX_W;
  localparam int unsigned TIMEOUT      = 32;
  localparam int unsigned BLOCK_CYCLES = 3;
  localparam int unsigned NB_RANDOM    = 400;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_IDLE} op_e;

  // one row of the stimulus table
  typedef struct packed {
    op_e                          op;
    logic                         flush;
    logic [hci_pkg::ADDR_W-1:0]   addr;
    logic [hci_pkg::WIDE_BW-1:0]  be;
    logic [hci_pkg::WIDE_DW-1:0]  data;
    logic [hci_pkg::NB_BANKS-1:0] busy;
  } entry_t;

  logic                         clk;
  logic                         rst_n;
  logic                         clear;
  hci_pkg::hci_wide_req_t       req;
  logic                         gnt;
  logic [hci_pkg::NB_BANKS-1:0] busy;
  hci_pkg::hci_wide_resp_t      resp;

  // word index is row * NB_BANKS + bank
  logic [hci_pkg::LANE_DW-1:0] model_mem [MODEL_WORDS];
  entry_t                      table_q [$];
  hci_pkg::hci_wide_resp_t     exp_resp;
  logic                        exp_data;
  logic [31:0]                 lcg_state;
  logic                        run_passed;
  logic                        fail_printed;

  tb_clock_gen u_clk (.clk_o(clk), .rst_no(rst_n));

  hci_wide_port_top u_dut (
    .clk_i       ( clk   ),
    .rst_ni      ( rst_n ),
    .clear_i     ( clear ),
    .req_i       ( req   ),
    .gnt_o       ( gnt   ),
    .bank_busy_i ( busy  ),
    .resp_o      ( resp  )
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // lane i of an access covers word (address/4)+i, wrapping at the top
  function automatic logic [WIDX_W-1:0] word_index(input logic [hci_pkg::ADDR_W-1:0] addr,
                                                   input int unsigned lane);
    return WIDX_W'(addr[hci_pkg::ADDR_W-1:2] + lane);
  endfunction

  function automatic logic [hci_pkg::NB_BANKS-1:0] touched_mask(
    input logic [hci_pkg::ADDR_W-1:0] addr);
    logic [hci_pkg::NB_BANKS-1:0] m;
    logic [WIDX_W-1:0]            w;
    m = '0;
    for (int unsigned i = 0; i < hci_pkg::NB_LANES; i++) begin
      w = word_index(addr, i);
      m[w[hci_pkg::OFS_W-1:0]] = 1'b1;
    end
    return m;
  endfunction

  function automatic logic [31:0] fill_word(input logic [WIDX_W-1:0] w);
    return {w, 5'h15, ~w, 5'h0a};
  endfunction

  function automatic entry_t make_entry(input op_e op, input logic flush,
                                        input logic [hci_pkg::ADDR_W-1:0] addr,
                                        input logic [hci_pkg::WIDE_BW-1:0] be,
                                        input logic [hci_pkg::WIDE_DW-1:0] data,
                                        input logic [hci_pkg::NB_BANKS-1:0] bsy);
    entry_t e;
    e.op    = op;
    e.flush = flush;
    e.addr  = addr;
    e.be    = be;
    e.data  = data;
    e.busy  = bsy;
    return e;
  endfunction

  task automatic fail_stop();
    fail_printed = 1'b1;
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_gnt(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s gnt_o=%b expected %b", $time, what, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_resp(input hci_pkg::hci_wide_resp_t got,
                            input hci_pkg::hci_wide_resp_t exp,
                            input logic with_data, input string what);
    if (got.r_valid !== exp.r_valid) begin
      $display("MISMATCH at %0t: %s r_valid=%b expected %b",
               $time, what, got.r_valid, exp.r_valid);
      fail_stop();
    end else if (with_data && got.r_data !== exp.r_data) begin
      $display("MISMATCH at %0t: %s r_data=%h expected %h",
               $time, what, got.r_data, exp.r_data);
      fail_stop();
    end
  endtask

  // response owed from the previous cycle, then nothing unless granted again
  task automatic sample_resp(input string what);
    check_resp(resp, exp_resp, exp_data, what);
    exp_resp.r_valid = 1'b0;
    exp_data         = 1'b0;
  endtask

  task automatic accept_grant(input entry_t e);
    logic [WIDX_W-1:0] w;
    for (int unsigned i = 0; i < hci_pkg::NB_LANES; i++) begin
      w = word_index(e.addr, i);
      for (int unsigned k = 0; k < hci_pkg::LANE_BW; k++) begin
        if (e.op == OP_WR && e.be[i*hci_pkg::LANE_BW+k]) begin
          model_mem[w][k*8 +: 8] = e.data[(i*hci_pkg::LANE_BW+k)*8 +: 8];
        end
      end
      exp_resp.r_data[i*hci_pkg::LANE_DW +: hci_pkg::LANE_DW] = model_mem[w];
    end
    // a flush in the grant cycle drops the response
    exp_resp.r_valid = !e.flush;
    exp_data         = (e.op == OP_RD) && !e.flush;
  endtask

  task automatic run_access(input entry_t e);
    hci_pkg::hci_wide_req_t r;
    int unsigned            waited;
    logic                   granted;
    logic                   exp_g;
    r.req     = 1'b1;
    r.wen     = (e.op == OP_RD);
    r.add.raw = e.addr;
    r.be      = e.be;
    r.data    = e.data;
    @(posedge clk);
    req   <= r;
    busy  <= e.busy;
    clear <= e.flush;
    waited  = 0;
    granted = 1'b0;
    while (!granted) begin
      @(negedge clk);
      sample_resp(e.op == OP_RD ? "read" : "write");
      exp_g = ((touched_mask(e.addr) & busy) == '0);
      check_gnt(gnt, exp_g, "access");
      if (gnt) begin
        granted = 1'b1;
        accept_grant(e);
      end else begin
        waited++;
        if (waited > TIMEOUT) begin
          $display("no grant within %0d cycles at %0t", TIMEOUT, $time);
          fail_stop();
        end
        // other initiators let go of the banks after a while
        if (waited == BLOCK_CYCLES) begin
          @(posedge clk);
          busy <= '0;
        end
      end
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    req   <= '0;
    busy  <= '0;
    clear <= 1'b0;
    @(negedge clk);
    sample_resp("idle");
    check_gnt(gnt, 1'b0, "idle");
  endtask

  task automatic load_table();
    logic [hci_pkg::WIDE_DW-1:0] d;
    // aligned round trip at bank 0
    d = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;
    table_q.push_back(make_entry(OP_WR, 1'b0, 13'h0040, '1, d, '0));
    table_q.push_back(make_entry(OP_RD, 1'b0, 13'h0040, '0, '0, '0));
    table_q.push_back(make_entry(OP_IDLE, 1'b0, '0, '0, '0, '0));
    // bank offset 6, lanes 2 and 3 land in the next row
    d = 128'hdead_beef_cafe_f00d_1357_9bdf_2468_ace0;
    table_q.push_back(make_entry(OP_WR, 1'b0, 13'h00b8, '1, d, '0));
    table_q.push_back(make_entry(OP_RD, 1'b0, 13'h00b8, '0, '0, '0));
    table_q.push_back(make_entry(OP_RD, 1'b0, 13'h00bc, '0, '0, '0));
    table_q.push_back(make_entry(OP_RD, 1'b0, 13'h00c0, '0, '0, '0));
    table_q.push_back(make_entry(OP_RD, 1'b0, 13'h00c4, '0, '0, '0));
    // last row wraps to row 0
    table_q.push_back(make_entry(OP_WR, 1'b0, 13'h1ffc, '1, ~d, '0));
    table_q.push_back(make_entry(OP_RD, 1'b0, 13'h1ffc, '0, '0, '0));
    // partial write keeps the disabled bytes
    d = 128'haaaa_bbbb_cccc_dddd_eeee_ffff_1111_2222;
    table_q.push_back(make_entry(OP_WR, 1'b0, 13'h0300, 16'h0f35, d, '0));
    table_q.push_back(make_entry(OP_RD, 1'b0, 13'h0300, '0, '0, '0));
    // touched bank busy holds the request, untouched busy does not
    d = 128'h5555_6666_7777_8888_9999_0000_abab_cdcd;
    table_q.push_back(make_entry(OP_WR, 1'b0, 13'h0400, '1, d, 8'h06));
    table_q.push_back(make_entry(OP_RD, 1'b0, 13'h0400, '0, '0, 8'h30));
    table_q.push_back(make_entry(OP_RD, 1'b0, 13'h0410, '0, '0, 8'h80));
    // flushed read gives no response
    table_q.push_back(make_entry(OP_RD, 1'b1, 13'h0040, '0, '0, '0));
    table_q.push_back(make_entry(OP_IDLE, 1'b0, '0, '0, '0, '0));
  endtask

  initial begin
    entry_t      e;
    int unsigned n;
    logic [31:0] r;
    logic [31:0] r2;
    lcg_state    = 32'h171f_0ee7;
    run_passed   = 1'b0;
    fail_printed = 1'b0;
    clear        = 1'b0;
    req          = '0;
    busy         = '0;
    exp_resp     = '0;
    exp_data     = 1'b0;
    // r_valid stays low through reset
    n = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      sample_resp("reset");
      n++;
      if (n > TIMEOUT) begin
        $display("reset was never released");
        fail_stop();
      end
    end
    // preload every word, back to back
    for (int unsigned k = 0; k < MODEL_WORDS / hci_pkg::NB_LANES; k++) begin
      e = make_entry(OP_WR, 1'b0, hci_pkg::ADDR_W'(k * 16), '1, '0, '0);
      for (int unsigned i = 0; i < hci_pkg::NB_LANES; i++) begin
        e.data[i*hci_pkg::LANE_DW +: hci_pkg::LANE_DW] =
          fill_word(WIDX_W'(k * hci_pkg::NB_LANES + i));
      end
      run_access(e);
    end
    load_table();
    foreach (table_q[j]) begin
      if (table_q[j].op == OP_IDLE) begin
        idle_cycle();
      end else begin
        run_access(table_q[j]);
      end
    end
    // random mix, busy now and then
    for (int unsigned k = 0; k < NB_RANDOM; k++) begin
      r  = next_rand();
      r2 = next_rand();
      e  = make_entry(r[16] ? OP_RD : OP_WR, 1'b0, r[hci_pkg::ADDR_W-1:0], r2[31:16], '0,
                      (r2[3:0] == 4'h0) ? r2[11:4] : 8'h00);
      for (int unsigned i = 0; i < hci_pkg::NB_LANES; i++) begin
        e.data[i*hci_pkg::LANE_DW +: hci_pkg::LANE_DW] = next_rand();
      end
      if (r[31:28] == 4'h0) begin
        idle_cycle();
      end else begin
        run_access(e);
      end
    end
    idle_cycle();
    run_passed = 1'b1;
    $display("TEST OK");
    $finish;
  end

  // run stopped by something other than the checks above
  final begin
    if (!run_passed && !fail_printed) begin
      $display("TEST FAILED");
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
/*
  clock and reset source for the testbench
  8 ns clock, reset held low for 5 cycles
*/

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== design/hci_addr_decode.sv ====
/*
  decode stage of the wide port
  splits the byte address into bank offset and row
  cuts data and byte enables into lanes with wrap-adjusted rows
  builds the mask of banks the request touches
*/

`timescale 1ns/1ps
`default_nettype none

module hci_addr_decode (
  input  hci_pkg::hci_wide_req_t  req_i,
  output hci_pkg::hci_lane_req_t  lane_o [hci_pkg::NB_LANES],
  output logic [hci_pkg::OFS_W-1:0]    offset_o,
  output logic [hci_pkg::NB_BANKS-1:0] touched_o
);

  // field view of the address, the two low bits are dropped
  logic [hci_pkg::BANK_AW-1:0] row_s;
  logic [hci_pkg::OFS_W-1:0]   ofs_s;

  assign row_s    = req_i.add.f.row;
  assign ofs_s    = req_i.add.f.bank_ofs;
  assign offset_o = ofs_s;

  // per-lane slices of the wide request
  always_comb begin
    for (int i = 0; i < hci_pkg::NB_LANES; i++) begin
      // handshake and direction are shared by all lanes
      lane_o[i].req  = req_i.req;
      lane_o[i].wen  = req_i.wen;
      lane_o[i].be   = req_i.be[i*hci_pkg::LANE_BW +: hci_pkg::LANE_BW];
      lane_o[i].data = req_i.data[i*hci_pkg::LANE_DW +: hci_pkg::LANE_DW];
      // lane whose bank index passes the last bank moves to the next row
      if ((ofs_s + i) >= hci_pkg::NB_BANKS) begin
        lane_o[i].row = row_s + 1'b1;
      end else begin
        lane_o[i].row = row_s;
      end
    end
  end

  // one bit per bank that some lane lands on
  always_comb begin
    touched_o = '0;
    for (int i = 0; i < hci_pkg::NB_LANES; i++) begin
      // bank index wraps modulo the bank count
      touched_o[hci_pkg::OFS_W'(ofs_s + i)] = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/hci_bank_array.sv ====
/*
  word-interleaved memory banks
  eight single-port 32-bit SRAMs of 256 rows each
  byte-enabled writes, registered read data one cycle later
*/

`timescale 1ns/1ps
`default_nettype none

module hci_bank_array (
  input  logic                   clk_i,
  input  hci_pkg::hci_lane_vec_t bank_i,
  output logic [hci_pkg::NB_BANKS-1:0][hci_pkg::LANE_DW-1:0] rdata_o
);

  for (genvar b = 0; b < hci_pkg::NB_BANKS; b++) begin : gen_bank
    // storage of one bank
    logic [hci_pkg::LANE_DW-1:0] mem_q [2**hci_pkg::BANK_AW];
    logic [hci_pkg::LANE_DW-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
      if (bank_i[b].req) begin
        if (!bank_i[b].wen) begin
          // write only the enabled bytes
          for (int k = 0; k < hci_pkg::LANE_BW; k++) begin
            if (bank_i[b].be[k]) begin
              mem_q[bank_i[b].row][k*8 +: 8] <= bank_i[b].data[k*8 +: 8];
            end
          end
        end else begin
          // read word shows up in the next cycle
          rdata_q <= mem_q[bank_i[b].row];
        end
      end
    end

    // read data holds between reads
    assign rdata_o[b] = rdata_q;
  end

endmodule

`default_nettype wire

// ==== design/hci_lane_rotate.sv ====
/*
  execute stage of the wide port
  grants when every touched bank is free
  rotates lanes onto banks, untouched banks stay idle
  flags granted requests and granted reads
*/

`timescale 1ns/1ps
`default_nettype none

module hci_lane_rotate (
  input  hci_pkg::hci_lane_req_t       lane_i [hci_pkg::NB_LANES],
  input  logic [hci_pkg::OFS_W-1:0]    offset_i,
  input  logic [hci_pkg::NB_BANKS-1:0] touched_i,
  input  logic [hci_pkg::NB_BANKS-1:0] bank_busy_i,
  output logic                         gnt_o,
  output hci_pkg::hci_lane_vec_t       bank_o,
  output logic                         rd_fire_o,
  output logic                         fire_o
);

  logic any_busy_s;
  logic gnt_s;

  // a single busy bank among the touched ones blocks the whole access
  assign any_busy_s = |(touched_i & bank_busy_i);

  // req is common to all lanes, lane 0 carries it
  assign gnt_s = lane_i[0].req & ~any_busy_s;

  assign gnt_o  = gnt_s;
  assign fire_o = gnt_s;
  // wen high is a read
  assign rd_fire_o = gnt_s & lane_i[0].wen;

  // lane i lands on bank (offset+i) mod NB_BANKS
  always_comb begin
    bank_o = '0;
    for (int i = 0; i < hci_pkg::NB_LANES; i++) begin
      bank_o[hci_pkg::OFS_W'(offset_i + i)] = lane_i[i];
      // bank req only on grant, so a blocked request writes nothing
      bank_o[hci_pkg::OFS_W'(offset_i + i)].req = lane_i[i].req & gnt_s;
    end
  end

endmodule

`default_nettype wire

// ==== design/hci_pkg.sv ====
/*
  shared definitions for the wide port to banked memory subsystem
  lane, bank and width constants
  byte address union with a raw and a field view
  wide request, lane request and wide response structs
*/

`default_nettype none

package hci_pkg;

  // wide port is split into 32-bit lanes
  localparam int unsigned NB_LANES = 4;
  localparam int unsigned NB_BANKS = 8;
  // rows per bank are 2**BANK_AW
  localparam int unsigned BANK_AW  = 8;
  localparam int unsigned OFS_W    = 3;
  localparam int unsigned LANE_DW  = 32;
  localparam int unsigned WIDE_DW  = NB_LANES * LANE_DW;
  // one byte enable per data byte
  localparam int unsigned LANE_BW  = LANE_DW / 8;
  localparam int unsigned WIDE_BW  = WIDE_DW / 8;
  // row, bank offset and byte-in-word
  localparam int unsigned ADDR_W   = BANK_AW + OFS_W + 2;

  // word-interleaved view of a byte address
  typedef struct packed {
    logic [BANK_AW-1:0] row;
    logic [OFS_W-1:0]   bank_ofs;
    logic [1:0]         byte_ofs;
  } hci_addr_f_t;

  typedef union packed {
    logic [ADDR_W-1:0] raw;
    hci_addr_f_t       f;
  } hci_addr_u;

  // wen low means write, as on the memory side
  typedef struct packed {
    logic               req;
    logic               wen;
    hci_addr_u          add;
    logic [WIDE_BW-1:0] be;
    logic [WIDE_DW-1:0] data;
  } hci_wide_req_t;

  // one lane in lane order, or one bank request after rotation
  typedef struct packed {
    logic               req;
    logic               wen;
    logic [BANK_AW-1:0] row;
    logic [LANE_BW-1:0] be;
    logic [LANE_DW-1:0] data;
  } hci_lane_req_t;

  typedef hci_lane_req_t [NB_BANKS-1:0] hci_lane_vec_t;

  typedef struct packed {
    logic               r_valid;
    logic [WIDE_DW-1:0] r_data;
  } hci_wide_resp_t;

endpackage

`default_nettype wire

// ==== design/hci_resp_gather.sv ====
/*
  result stage of the wide port
  registers grant and bank offset for one cycle
  unrotates bank read data into lane order and raises r_valid
*/

`timescale 1ns/1ps
`default_nettype none

module hci_resp_gather (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      fire_i,
  input  logic [hci_pkg::OFS_W-1:0] offset_i,
  input  logic [hci_pkg::NB_BANKS-1:0][hci_pkg::LANE_DW-1:0] rdata_i,
  output hci_pkg::hci_wide_resp_t   resp_o
);

  logic                      fire_q;
  logic [hci_pkg::OFS_W-1:0] ofs_q;
  logic [hci_pkg::WIDE_DW-1:0] r_data_s;

  // grant and offset follow the banks by exactly one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fire_q <= 1'b0;
      ofs_q  <= '0;
    end else if (clear_i) begin
      // flush drops a response in flight
      fire_q <= 1'b0;
      ofs_q  <= '0;
    end else begin
      fire_q <= fire_i;
      ofs_q  <= offset_i;
    end
  end

  // lane i comes from bank (offset+i) mod NB_BANKS
  always_comb begin
    r_data_s = '0;
    for (int i = 0; i < hci_pkg::NB_LANES; i++) begin
      r_data_s[i*hci_pkg::LANE_DW +: hci_pkg::LANE_DW] =
        rdata_i[hci_pkg::OFS_W'(ofs_q + i)];
    end
  end

  // r_valid for reads and writes alike, data only means something on reads
  assign resp_o.r_valid = fire_q;
  assign resp_o.r_data  = r_data_s;

endmodule

`default_nettype wire

// ==== design/hci_wide_port_top.sv ====
/*
  top level of the wide accelerator port
  decode, execute, memory banks and result stage
  external busy mask models other initiators on the banks
*/

`timescale 1ns/1ps
`default_nettype none

module hci_wide_port_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  hci_pkg::hci_wide_req_t       req_i,
  output logic                         gnt_o,
  input  logic [hci_pkg::NB_BANKS-1:0] bank_busy_i,
  output hci_pkg::hci_wide_resp_t      resp_o
);

  // decode to execute
  hci_pkg::hci_lane_req_t       lane_s [hci_pkg::NB_LANES];
  logic [hci_pkg::OFS_W-1:0]    offset_s;
  logic [hci_pkg::NB_BANKS-1:0] touched_s;

  // execute to banks and result stage
  hci_pkg::hci_lane_vec_t bank_s;
  logic                   fire_s;
  logic [hci_pkg::NB_BANKS-1:0][hci_pkg::LANE_DW-1:0] rdata_s;

  hci_addr_decode u_decode (
    .req_i     ( req_i     ),
    .lane_o    ( lane_s    ),
    .offset_o  ( offset_s  ),
    .touched_o ( touched_s )
  );

  // granted read strobe stays inside the execute stage
  hci_lane_rotate u_rotate (
    .lane_i      ( lane_s      ),
    .offset_i    ( offset_s    ),
    .touched_i   ( touched_s   ),
    .bank_busy_i ( bank_busy_i ),
    .gnt_o       ( gnt_o       ),
    .bank_o      ( bank_s      ),
    .rd_fire_o   (             ),
    .fire_o      ( fire_s      )
  );

  hci_bank_array u_banks (
    .clk_i   ( clk_i   ),
    .bank_i  ( bank_s  ),
    .rdata_o ( rdata_s )
  );

  hci_resp_gather u_gather (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .clear_i  ( clear_i  ),
    .fire_i   ( fire_s   ),
    .offset_i ( offset_s ),
    .rdata_i  ( rdata_s  ),
    .resp_o   ( resp_o   )
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the wide port testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module hci_wide_port_tb -f vlog.f -o sim_tb
out="$(./obj_dir/sim_tb 2>&1)" || true
echo "$out"
grep -qx "TEST OK" <<< "$out"

// ==== vlog.f ====
design/hci_pkg.sv
design/hci_addr_decode.sv
design/hci_lane_rotate.sv
design/hci_bank_array.sv
design/hci_resp_gather.sv
design/hci_wide_port_top.sv
bench/tb_clock_gen.sv
bench/hci_wide_port_sva.sv
bench/hci_wide_port_tb.sv
